//--- lce_cmd_top.f
+incdir+.
lce_pkg.sv
lce_cfg_regs.sv
lce_phase_ctrl.sv
lce_cmd_decode.sv
lce_cmd_top.sv
tb_lce_cmd.sv

//--- Bender.yml
package:
  name: lce_cmd

sources:
  - include_dirs:
      - .
    files:
      - lce_pkg.sv
      - lce_cfg_regs.sv
      - lce_phase_ctrl.sv
      - lce_cmd_decode.sv
      - lce_cmd_top.sv
      - target: test
        files:
          - tb_lce_cmd.sv

//--- tb_lce_cmd.sv
// testbench for lce_cmd_top: reset sweep, apb config registers, table of commands under random ready
`timescale 1ns/100ps

`include "lce_consts.svh"

module tb_lce_cmd
  import lce_pkg::*;
();

  // sweep, apb traffic and the table take a few hundred cycles even under heavy back-pressure
  localparam int CYCLE_LIMIT = 2000;
  localparam int MAX_ROWS = 16;
  localparam logic [1:0] NO_RESP = 2'd3;
  localparam lce_id_t LCE_ID = 2'd2;

  logic clk_i;
  logic reset_i;
  logic psel_i, penable_i, pwrite_i;
  logic [`APB_ADDR_W-1:0] paddr_i;
  logic [31:0] pwdata_i, prdata_o;
  logic pready_o, pslverr_o;
  paddr_t miss_addr_i, cmd_addr_i, resp_addr_o;
  logic cmd_v_i, cmd_yumi_o;
  lce_cmd_type_e cmd_type_i;
  cce_id_t cmd_src_i, resp_dst_o;
  way_t cmd_way_i, tag_pkt_way_o, data_pkt_way_o;
  coh_state_t cmd_state_i, tag_pkt_state_o;
  block_t cmd_data_i, data_pkt_data_o;
  logic tag_pkt_v_o, tag_pkt_ready_i, stat_pkt_v_o, stat_pkt_ready_i;
  logic data_pkt_v_o, data_pkt_ready_i, resp_v_o, resp_yumi_i;
  tag_op_e tag_pkt_op_o;
  stat_op_e stat_pkt_op_o;
  data_op_e data_pkt_op_o;
  set_index_t tag_pkt_index_o, stat_pkt_index_o, data_pkt_index_o;
  tag_t tag_pkt_tag_o;
  lce_resp_type_e resp_type_o;
  lce_id_t resp_src_o;
  logic lce_ready_o, set_tag_received_o, set_tag_wakeup_received_o;
  logic cce_data_received_o, uncached_data_received_o, cache_req_complete_o;

  // command columns
  lce_cmd_type_e r_type [MAX_ROWS];
  paddr_t r_addr [MAX_ROWS];
  paddr_t r_miss [MAX_ROWS];
  cce_id_t r_src [MAX_ROWS];
  way_t r_way [MAX_ROWS];
  coh_state_t r_state [MAX_ROWS];
  block_t r_data [MAX_ROWS];
  // expected: packets {tag, stat, data}, strobes {set_tag, wakeup, cce_data, uc_data, complete}
  logic [2:0] x_pkts [MAX_ROWS];
  tag_op_e x_tag_op [MAX_ROWS];
  set_index_t x_idx [MAX_ROWS];
  tag_t x_tag [MAX_ROWS];
  data_op_e x_data_op [MAX_ROWS];
  logic [1:0] x_resp [MAX_ROWS];
  logic [4:0] x_strb [MAX_ROWS];
  logic x_take [MAX_ROWS];

  int nrows = 0;
  int errors = 0;
  int cycles = 0;
  integer seed = 60;

  lce_cmd_top dut (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  // high about three cycles out of four
  function automatic logic rnd_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[1:0] != 2'b00;
  endfunction

  task automatic add_row(input lce_cmd_type_e typ, input paddr_t addr, input cce_id_t src,
                         input way_t way, input coh_state_t st, input paddr_t miss,
                         input logic [2:0] pkts, input tag_op_e op, input set_index_t idx,
                         input tag_t tag, input data_op_e dop, input logic [1:0] resp,
                         input logic [4:0] strb, input logic take);
    r_type[nrows] = typ;
    r_addr[nrows] = addr;
    r_src[nrows] = src;
    r_way[nrows] = way;
    r_state[nrows] = st;
    r_miss[nrows] = miss;
    r_data[nrows] = {$random(seed), $random(seed)};
    x_pkts[nrows] = pkts;
    x_tag_op[nrows] = op;
    x_idx[nrows] = idx;
    x_tag[nrows] = tag;
    x_data_op[nrows] = dop;
    x_resp[nrows] = resp;
    x_strb[nrows] = strb;
    x_take[nrows] = take;
    nrows++;
  endtask

  // for a read, data is the expected read value
  task automatic apb_access(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                            input logic [31:0] data, input logic exp_err);
    @(posedge clk_i);
    psel_i <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i <= wr;
    paddr_i <= addr;
    pwdata_i <= data;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    if (!pready_o || pslverr_o !== exp_err) begin
      report_error($sformatf("apb offset %0h: pready %0b pslverr %0b, expected pslverr %0b",
                             addr, pready_o, pslverr_o, exp_err));
    end
    if (!wr && prdata_o !== data) begin
      report_error($sformatf("apb read of offset %0h gave %0h, expected %0h",
                             addr, prdata_o, data));
    end
    @(posedge clk_i);
    psel_i <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic run_row(input int i);
    int held;
    int tag_taken;
    int yumi_hold;
    logic done;
    logic [4:0] strobes;
    held = 0;
    tag_taken = 0;
    yumi_hold = 1 + ($random(seed) & 3);
    done = 1'b0;
    @(posedge clk_i);
    cmd_v_i <= 1'b1;
    cmd_type_i <= r_type[i];
    cmd_addr_i <= r_addr[i];
    cmd_src_i <= r_src[i];
    cmd_way_i <= r_way[i];
    cmd_state_i <= r_state[i];
    cmd_data_i <= r_data[i];
    miss_addr_i <= r_miss[i];
    while (!done) begin
      tag_pkt_ready_i <= rnd_bit();
      stat_pkt_ready_i <= rnd_bit();
      data_pkt_ready_i <= rnd_bit();
      // inv_ack is left waiting a few cycles after the tag write
      if (x_resp[i] == e_resp_inv_ack) begin
        resp_yumi_i <= (tag_taken > 0) && (yumi_hold == 0);
      end else begin
        resp_yumi_i <= rnd_bit();
      end
      @(negedge clk_i);
      if (tag_pkt_v_o && (!tag_pkt_ready_i || !x_pkts[i][2] || tag_pkt_op_o !== x_tag_op[i]
          || tag_pkt_index_o !== x_idx[i])) begin
        report_error($sformatf("row %0d: tag packet op %0d index %0d not expected",
                               i, tag_pkt_op_o, tag_pkt_index_o));
      end
      if (tag_pkt_v_o && tag_pkt_op_o != e_tag_set_clear && tag_pkt_way_o !== r_way[i]) begin
        report_error($sformatf("row %0d: tag packet way %0d", i, tag_pkt_way_o));
      end
      if (tag_pkt_v_o && tag_pkt_op_o == e_tag_set_tag
          && (tag_pkt_tag_o !== x_tag[i] || tag_pkt_state_o !== r_state[i])) begin
        report_error($sformatf("row %0d: tag %0h state %0d, expected tag %0h",
                               i, tag_pkt_tag_o, tag_pkt_state_o, x_tag[i]));
      end
      if (stat_pkt_v_o && (!stat_pkt_ready_i || !x_pkts[i][1]
          || stat_pkt_op_o !== e_stat_set_clear || stat_pkt_index_o !== x_idx[i])) begin
        report_error($sformatf("row %0d: stat packet op %0d index %0d not expected",
                               i, stat_pkt_op_o, stat_pkt_index_o));
      end
      if (data_pkt_v_o && (!data_pkt_ready_i || !x_pkts[i][0] || data_pkt_op_o !== x_data_op[i]
          || data_pkt_index_o !== x_idx[i] || data_pkt_data_o !== r_data[i]
          || data_pkt_way_o !== r_way[i])) begin
        report_error($sformatf("row %0d: data packet op %0d index %0d way %0d not expected",
                               i, data_pkt_op_o, data_pkt_index_o, data_pkt_way_o));
      end
      if (resp_v_o && (x_resp[i] == NO_RESP || resp_type_o !== x_resp[i]
          || resp_src_o !== LCE_ID || resp_dst_o !== r_src[i]
          || (resp_type_o == e_resp_null_wb && resp_addr_o !== r_addr[i]))) begin
        report_error($sformatf("row %0d: response type %0d src %0d dst %0d addr %0h",
                               i, resp_type_o, resp_src_o, resp_dst_o, resp_addr_o));
      end
      if (x_resp[i] == e_resp_inv_ack && tag_taken > 0 && !resp_v_o) begin
        report_error($sformatf("row %0d: inv_ack dropped before yumi", i));
      end
      strobes = {set_tag_received_o, set_tag_wakeup_received_o, cce_data_received_o,
                 uncached_data_received_o, cache_req_complete_o};
      if (strobes !== (cmd_yumi_o ? x_strb[i] : 5'b00000)) begin
        report_error($sformatf("row %0d: strobes %05b with yumi %0b", i, strobes, cmd_yumi_o));
      end
      // the invalidate tag write happens before the consuming cycle
      if (cmd_yumi_o && (!x_take[i]
          || (x_pkts[i][2] && !tag_pkt_v_o && x_tag_op[i] != e_tag_invalidate)
          || (x_pkts[i][1] && !stat_pkt_v_o) || (x_pkts[i][0] && !data_pkt_v_o)
          || (x_resp[i] != NO_RESP && !(resp_v_o && resp_yumi_i)))) begin
        report_error($sformatf("row %0d: command consumed without its packets or response", i));
      end
      if (tag_taken > 0 && yumi_hold > 0) begin
        yumi_hold--;
      end
      if (tag_pkt_v_o && tag_pkt_ready_i) begin
        tag_taken++;
      end
      held++;
      // a command the phase does not accept is held a while and then withdrawn
      done = cmd_yumi_o || (!x_take[i] && held == 6);
      if (!done) begin
        @(posedge clk_i);
      end
    end
    if (x_pkts[i][2] && x_tag_op[i] == e_tag_invalidate && tag_taken != 1) begin
      report_error($sformatf("row %0d: %0d invalidate packets, expected 1", i, tag_taken));
    end
    @(posedge clk_i);
    cmd_v_i <= 1'b0;
    tag_pkt_ready_i <= 1'b0;
    stat_pkt_ready_i <= 1'b0;
    data_pkt_ready_i <= 1'b0;
    resp_yumi_i <= 1'b0;
  endtask

  initial begin
    int steps;
    clk_i = 1'b0;
    reset_i = 1'b1;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    miss_addr_i = '0;
    cmd_v_i = 1'b0;
    cmd_type_i = e_cmd_set_clear;
    cmd_addr_i = '0;
    cmd_src_i = '0;
    cmd_way_i = '0;
    cmd_state_i = '0;
    cmd_data_i = '0;
    tag_pkt_ready_i = 1'b0;
    stat_pkt_ready_i = 1'b0;
    data_pkt_ready_i = 1'b0;
    resp_yumi_i = 1'b0;

    // rows 0..5 run in uncached_only, the third sync moves the engine to ready
    add_row(e_cmd_set_clear, 16'h1234, 2'd0, 2'd0, 2'd0, 16'h0000, 3'b110, e_tag_set_clear,
            3'd6, 10'h000, e_data_write, NO_RESP, 5'b00000, 1'b1);
    add_row(e_cmd_uc_data, 16'h1234, 2'd0, 2'd0, 2'd0, 16'h0028, 3'b001, e_tag_set_clear,
            3'd5, 10'h000, e_data_uncached, NO_RESP, 5'b00011, 1'b1);
    add_row(e_cmd_sync, 16'h0000, 2'd1, 2'd0, 2'd0, 16'h0000, 3'b000, e_tag_set_clear,
            3'd0, 10'h000, e_data_write, e_resp_sync_ack, 5'b00000, 1'b1);
    add_row(e_cmd_set_tag, 16'h0F38, 2'd0, 2'd2, 2'd1, 16'h0000, 3'b000, e_tag_set_tag,
            3'd7, 10'h03C, e_data_write, NO_RESP, 5'b00000, 1'b0);
    add_row(e_cmd_sync, 16'h0000, 2'd2, 2'd0, 2'd0, 16'h0000, 3'b000, e_tag_set_clear,
            3'd0, 10'h000, e_data_write, e_resp_sync_ack, 5'b00000, 1'b1);
    add_row(e_cmd_sync, 16'h0000, 2'd3, 2'd0, 2'd0, 16'h0000, 3'b000, e_tag_set_clear,
            3'd0, 10'h000, e_data_write, e_resp_sync_ack, 5'b00000, 1'b1);
    add_row(e_cmd_uc_data, 16'hABC8, 2'd0, 2'd0, 2'd0, 16'h7FD8, 3'b001, e_tag_set_clear,
            3'd3, 10'h000, e_data_uncached, NO_RESP, 5'b00011, 1'b1);
    add_row(e_cmd_data, 16'hABC8, 2'd1, 2'd1, 2'd2, 16'h7FD8, 3'b101, e_tag_set_tag,
            3'd3, 10'h2AF, e_data_write, NO_RESP, 5'b10101, 1'b1);
    add_row(e_cmd_set_tag, 16'h0F38, 2'd0, 2'd2, 2'd1, 16'h0000, 3'b100, e_tag_set_tag,
            3'd7, 10'h03C, e_data_write, NO_RESP, 5'b10000, 1'b1);
    add_row(e_cmd_set_tag_wakeup, 16'h4010, 2'd0, 2'd3, 2'd3, 16'h0000, 3'b100, e_tag_set_tag,
            3'd2, 10'h100, e_data_write, NO_RESP, 5'b01001, 1'b1);
    add_row(e_cmd_invalidate_tag, 16'h1234, 2'd1, 2'd1, 2'd0, 16'h0000, 3'b100,
            e_tag_invalidate, 3'd6, 10'h000, e_data_write, e_resp_inv_ack, 5'b00000, 1'b1);
    add_row(e_cmd_writeback, 16'hABC8, 2'd2, 2'd0, 2'd0, 16'h0000, 3'b000, e_tag_set_clear,
            3'd0, 10'h000, e_data_write, e_resp_null_wb, 5'b00000, 1'b1);
    add_row(e_cmd_set_clear, 16'h4010, 2'd0, 2'd0, 2'd0, 16'h0000, 3'b110, e_tag_set_clear,
            3'd2, 10'h000, e_data_write, NO_RESP, 5'b00000, 1'b1);

    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;

    // reset sweep, one set per cycle in which both memories are ready
    steps = 0;
    while (steps < `LCE_SETS) begin
      @(posedge clk_i);
      tag_pkt_ready_i <= rnd_bit();
      stat_pkt_ready_i <= rnd_bit();
      @(negedge clk_i);
      if (lce_ready_o) begin
        report_error("lce_ready_o high during the sweep");
      end
      if (tag_pkt_v_o !== tag_pkt_ready_i || stat_pkt_v_o !== stat_pkt_ready_i) begin
        report_error("sweep packet valid does not follow ready");
      end
      if (tag_pkt_v_o && (tag_pkt_op_o !== e_tag_set_clear
          || tag_pkt_index_o !== set_index_t'(steps))) begin
        report_error($sformatf("sweep tag index %0d, expected %0d", tag_pkt_index_o, steps));
      end
      if (stat_pkt_v_o && (stat_pkt_op_o !== e_stat_set_clear
          || stat_pkt_index_o !== set_index_t'(steps))) begin
        report_error($sformatf("sweep stat op %0d index %0d, expected index %0d",
                               stat_pkt_op_o, stat_pkt_index_o, steps));
      end
      if (data_pkt_v_o || resp_v_o || cmd_yumi_o) begin
        report_error("data, response or yumi active during the sweep");
      end
      if (tag_pkt_v_o && stat_pkt_v_o) begin
        steps++;
      end
    end
    @(posedge clk_i);
    tag_pkt_ready_i <= 1'b0;
    stat_pkt_ready_i <= 1'b0;
    @(negedge clk_i);
    if (!lce_ready_o) begin
      report_error("lce_ready_o low after the sweep");
    end
    apb_access(1'b0, `REG_STATUS, 32'(e_phase_uncached_only), 1'b0);

    apb_access(1'b1, `REG_LCE_ID, 32'(LCE_ID), 1'b0);
    apb_access(1'b0, `REG_LCE_ID, 32'(LCE_ID), 1'b0);
    apb_access(1'b1, `REG_NUM_CCE, 32'd0, 1'b0);
    apb_access(1'b0, `REG_NUM_CCE, 32'd1, 1'b0);
    apb_access(1'b1, `REG_NUM_CCE, 32'd3, 1'b0);
    apb_access(1'b0, `REG_NUM_CCE, 32'd3, 1'b0);
    apb_access(1'b1, 4'hC, 32'h5A, 1'b1);
    apb_access(1'b0, 4'hC, 32'd0, 1'b1);

    for (int i = 0; i < nrows; i++) begin
      run_row(i);
      // two syncs taken out of three
      if (i == 4) begin
        apb_access(1'b0, `REG_STATUS, 32'(e_phase_uncached_only), 1'b0);
      end
      if (i == 5) begin
        apb_access(1'b0, `REG_STATUS, 32'(e_phase_ready), 1'b0);
      end
    end

    $display("rows applied: %0d, errors: %0d", nrows, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- lce_cmd_top.sv
// lce_cmd_top: lce command side with apb config, phase FSM and command decoder
`timescale 1ns/100ps

`include "lce_consts.svh"

module lce_cmd_top
  import lce_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`APB_ADDR_W-1:0] paddr_i,
  input  logic [31:0]            pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  input  paddr_t                 miss_addr_i,
  input  logic                   cmd_v_i,
  input  lce_cmd_type_e          cmd_type_i,
  input  paddr_t                 cmd_addr_i,
  input  cce_id_t                cmd_src_i,
  input  way_t                   cmd_way_i,
  input  coh_state_t             cmd_state_i,
  input  block_t                 cmd_data_i,
  output logic                   cmd_yumi_o,
  output logic                   tag_pkt_v_o,
  output tag_op_e                tag_pkt_op_o,
  output set_index_t             tag_pkt_index_o,
  output way_t                   tag_pkt_way_o,
  output coh_state_t             tag_pkt_state_o,
  output tag_t                   tag_pkt_tag_o,
  input  logic                   tag_pkt_ready_i,
  output logic                   stat_pkt_v_o,
  output stat_op_e               stat_pkt_op_o,
  output set_index_t             stat_pkt_index_o,
  input  logic                   stat_pkt_ready_i,
  output logic                   data_pkt_v_o,
  output data_op_e               data_pkt_op_o,
  output set_index_t             data_pkt_index_o,
  output way_t                   data_pkt_way_o,
  output block_t                 data_pkt_data_o,
  input  logic                   data_pkt_ready_i,
  output logic                   resp_v_o,
  output lce_resp_type_e         resp_type_o,
  output lce_id_t                resp_src_o,
  output cce_id_t                resp_dst_o,
  output paddr_t                 resp_addr_o,
  input  logic                   resp_yumi_i,
  output logic                   lce_ready_o,
  output logic                   set_tag_received_o,
  output logic                   set_tag_wakeup_received_o,
  output logic                   cce_data_received_o,
  output logic                   uncached_data_received_o,
  output logic                   cache_req_complete_o
);

  lce_id_t lce_id;
  logic [`NUM_CCE_W-1:0] num_cce;
  lce_phase_e phase;
  set_index_t sweep_index;
  logic sweep_step;
  logic sync_done;

  lce_cfg_regs u_cfg_regs (.*, .phase_i(phase), .lce_id_o(lce_id), .num_cce_o(num_cce));

  lce_phase_ctrl u_phase_ctrl (
    .clk_i, .reset_i, .sweep_step_i(sweep_step), .sync_done_i(sync_done),
    .num_cce_i(num_cce), .phase_o(phase), .sweep_index_o(sweep_index)
  );

  lce_cmd_decode u_cmd_decode (
    .*, .phase_i(phase), .sweep_index_i(sweep_index), .lce_id_i(lce_id),
    .sweep_step_o(sweep_step), .sync_done_o(sync_done)
  );

endmodule

//--- lce_cmd_decode.sv
// lce_cmd_decode: command decode into tag/stat/data packets, responses and status strobes
`timescale 1ns/100ps

`include "lce_consts.svh"

module lce_cmd_decode
  import lce_pkg::*;
(
  input  logic           clk_i,
  input  logic           reset_i,
  input  lce_phase_e     phase_i,
  input  set_index_t     sweep_index_i,
  input  lce_id_t        lce_id_i,
  input  paddr_t         miss_addr_i,
  input  logic           cmd_v_i,
  input  lce_cmd_type_e  cmd_type_i,
  input  paddr_t         cmd_addr_i,
  input  cce_id_t        cmd_src_i,
  input  way_t           cmd_way_i,
  input  coh_state_t     cmd_state_i,
  input  block_t         cmd_data_i,
  output logic           cmd_yumi_o,
  output logic           tag_pkt_v_o,
  output tag_op_e        tag_pkt_op_o,
  output set_index_t     tag_pkt_index_o,
  output way_t           tag_pkt_way_o,
  output coh_state_t     tag_pkt_state_o,
  output tag_t           tag_pkt_tag_o,
  input  logic           tag_pkt_ready_i,
  output logic           stat_pkt_v_o,
  output stat_op_e       stat_pkt_op_o,
  output set_index_t     stat_pkt_index_o,
  input  logic           stat_pkt_ready_i,
  output logic           data_pkt_v_o,
  output data_op_e       data_pkt_op_o,
  output set_index_t     data_pkt_index_o,
  output way_t           data_pkt_way_o,
  output block_t         data_pkt_data_o,
  input  logic           data_pkt_ready_i,
  output logic           resp_v_o,
  output lce_resp_type_e resp_type_o,
  output lce_id_t        resp_src_o,
  output cce_id_t        resp_dst_o,
  output paddr_t         resp_addr_o,
  input  logic           resp_yumi_i,
  output logic           lce_ready_o,
  output logic           set_tag_received_o,
  output logic           set_tag_wakeup_received_o,
  output logic           cce_data_received_o,
  output logic           uncached_data_received_o,
  output logic           cache_req_complete_o,
  output logic           sweep_step_o,
  output logic           sync_done_o
);

  set_index_t cmd_index;
  set_index_t miss_index;
  tag_t cmd_tag;
  logic ready_phase;
  logic inv_pend_r;
  logic inv_pend_n;

  assign cmd_index   = cmd_addr_i[`BLOCK_OFFSET_W +: `INDEX_W];
  assign cmd_tag     = cmd_addr_i[`BLOCK_OFFSET_W + `INDEX_W +: `TAG_W];
  assign miss_index  = miss_addr_i[`BLOCK_OFFSET_W +: `INDEX_W];
  assign ready_phase = (phase_i == e_phase_ready);
  assign lce_ready_o = (phase_i != e_phase_sweep);

  always_comb begin
    cmd_yumi_o = 1'b0;
    tag_pkt_v_o = 1'b0;
    tag_pkt_op_o = e_tag_set_clear;
    tag_pkt_index_o = cmd_index;
    tag_pkt_way_o = cmd_way_i;
    tag_pkt_state_o = COH_I;
    tag_pkt_tag_o = '0;
    stat_pkt_v_o = 1'b0;
    stat_pkt_op_o = e_stat_set_clear;
    stat_pkt_index_o = cmd_index;
    data_pkt_v_o = 1'b0;
    data_pkt_op_o = e_data_write;
    data_pkt_index_o = miss_index;
    data_pkt_way_o = cmd_way_i;
    data_pkt_data_o = cmd_data_i;
    resp_v_o = 1'b0;
    resp_type_o = e_resp_sync_ack;
    resp_src_o = lce_id_i;
    resp_dst_o = cmd_src_i;
    resp_addr_o = cmd_addr_i;
    set_tag_received_o = 1'b0;
    set_tag_wakeup_received_o = 1'b0;
    cce_data_received_o = 1'b0;
    uncached_data_received_o = 1'b0;
    cache_req_complete_o = 1'b0;
    sweep_step_o = 1'b0;
    sync_done_o = 1'b0;
    inv_pend_n = inv_pend_r;

    if (phase_i == e_phase_sweep) begin
      // clear one set per step, each memory as soon as it is ready
      tag_pkt_v_o      = tag_pkt_ready_i;
      tag_pkt_index_o  = sweep_index_i;
      stat_pkt_v_o     = stat_pkt_ready_i;
      stat_pkt_index_o = sweep_index_i;
      sweep_step_o     = tag_pkt_v_o && stat_pkt_v_o;
    end else begin
      case (cmd_type_i)
        e_cmd_set_clear: begin
          tag_pkt_v_o  = cmd_v_i && tag_pkt_ready_i;
          stat_pkt_v_o = cmd_v_i && stat_pkt_ready_i;
          cmd_yumi_o   = tag_pkt_v_o && stat_pkt_v_o;
        end
        e_cmd_sync: begin
          resp_v_o    = cmd_v_i;
          cmd_yumi_o  = cmd_v_i && resp_yumi_i;
          sync_done_o = cmd_yumi_o;
        end
        e_cmd_uc_data: begin
          data_pkt_op_o            = e_data_uncached;
          data_pkt_v_o             = cmd_v_i && data_pkt_ready_i;
          cmd_yumi_o               = data_pkt_v_o;
          uncached_data_received_o = data_pkt_v_o;
          cache_req_complete_o     = data_pkt_v_o;
        end
        e_cmd_set_tag, e_cmd_set_tag_wakeup: begin
          tag_pkt_op_o    = e_tag_set_tag;
          tag_pkt_state_o = cmd_state_i;
          tag_pkt_tag_o   = cmd_tag;
          tag_pkt_v_o     = ready_phase && cmd_v_i && tag_pkt_ready_i;
          cmd_yumi_o      = tag_pkt_v_o;
          if (cmd_type_i == e_cmd_set_tag_wakeup) begin
            set_tag_wakeup_received_o = tag_pkt_v_o;
            cache_req_complete_o      = tag_pkt_v_o;
          end else begin
            set_tag_received_o = tag_pkt_v_o;
          end
        end
        e_cmd_invalidate_tag: begin
          // tag written once, then the ack waits for yumi
          tag_pkt_op_o = e_tag_invalidate;
          tag_pkt_v_o  = ready_phase && cmd_v_i && tag_pkt_ready_i && !inv_pend_r;
          resp_type_o  = e_resp_inv_ack;
          resp_v_o     = ready_phase && (inv_pend_r || tag_pkt_v_o);
          cmd_yumi_o   = resp_v_o && resp_yumi_i;
          inv_pend_n   = cmd_yumi_o ? 1'b0 : (inv_pend_r || tag_pkt_v_o);
        end
        e_cmd_data: begin
          tag_pkt_op_o        = e_tag_set_tag;
          tag_pkt_index_o     = miss_index;
          tag_pkt_state_o     = cmd_state_i;
          tag_pkt_tag_o       = cmd_tag;
          tag_pkt_v_o         = ready_phase && cmd_v_i && tag_pkt_ready_i;
          data_pkt_v_o        = ready_phase && cmd_v_i && data_pkt_ready_i;
          cmd_yumi_o          = tag_pkt_v_o && data_pkt_v_o;
          cce_data_received_o = cmd_yumi_o;
          set_tag_received_o  = cmd_yumi_o;
          cache_req_complete_o = cmd_yumi_o;
        end
        default: begin
          // writeback of a clean icache line
          resp_type_o = e_resp_null_wb;
          resp_v_o    = ready_phase && cmd_v_i;
          cmd_yumi_o  = resp_v_o && resp_yumi_i;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      inv_pend_r <= 1'b0;
    end else begin
      inv_pend_r <= inv_pend_n;
    end
  end

endmodule

//--- lce_phase_ctrl.sv
// lce_phase_ctrl: sweep / uncached-only / ready phase FSM with a shared step counter
`timescale 1ns/100ps

`include "lce_consts.svh"

module lce_phase_ctrl
  import lce_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  sweep_step_i,
  input  logic                  sync_done_i,
  input  logic [`NUM_CCE_W-1:0] num_cce_i,
  output lce_phase_e            phase_o,
  output set_index_t            sweep_index_o
);

  lce_phase_e phase_r;
  // counts swept sets, then acknowledged syncs
  logic [2:0] cnt_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      phase_r <= e_phase_sweep;
      cnt_r   <= '0;
    end else begin
      case (phase_r)
        e_phase_sweep: begin
          if (sweep_step_i) begin
            if (cnt_r == 3'(`LCE_SETS - 1)) begin
              phase_r <= e_phase_uncached_only;
              cnt_r   <= '0;
            end else begin
              cnt_r <= cnt_r + 3'd1;
            end
          end
        end
        e_phase_uncached_only: begin
          if (sync_done_i) begin
            if (cnt_r == num_cce_i - 3'd1) begin
              phase_r <= e_phase_ready;
              cnt_r   <= '0;
            end else begin
              cnt_r <= cnt_r + 3'd1;
            end
          end
        end
        default: phase_r <= phase_r;
      endcase
    end
  end

  assign phase_o       = phase_r;
  assign sweep_index_o = cnt_r;

endmodule

//--- lce_cfg_regs.sv
// lce_cfg_regs: apb slave holding the lce id and cce count, status register reports the phase
`timescale 1ns/100ps

`include "lce_consts.svh"

module lce_cfg_regs
  import lce_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [`APB_ADDR_W-1:0] paddr_i,
  input  logic [31:0]           pwdata_i,
  output logic [31:0]           prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  input  lce_phase_e            phase_i,
  output lce_id_t               lce_id_o,
  output logic [`NUM_CCE_W-1:0] num_cce_o
);

  lce_id_t lce_id_r;
  logic [`NUM_CCE_W-1:0] num_cce_r;
  logic mapped;
  logic wr_en;

  assign mapped = (paddr_i == `REG_LCE_ID) || (paddr_i == `REG_NUM_CCE)
                  || (paddr_i == `REG_STATUS);
  assign wr_en = psel_i && penable_i && pwrite_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lce_id_r  <= '0;
      num_cce_r <= `NUM_CCE_W'(1);
    end else if (wr_en) begin
      if (paddr_i == `REG_LCE_ID) begin
        lce_id_r <= pwdata_i[`LCE_ID_W-1:0];
      end
      // keep the count inside 1..MAX_CCE
      if (paddr_i == `REG_NUM_CCE) begin
        if (pwdata_i == 32'd0) begin
          num_cce_r <= `NUM_CCE_W'(1);
        end else if (pwdata_i > 32'(`MAX_CCE)) begin
          num_cce_r <= `NUM_CCE_W'(`MAX_CCE);
        end else begin
          num_cce_r <= pwdata_i[`NUM_CCE_W-1:0];
        end
      end
    end
  end

  always_comb begin
    prdata_o = '0;
    case (paddr_i)
      `REG_LCE_ID:  prdata_o = 32'(lce_id_r);
      `REG_NUM_CCE: prdata_o = 32'(num_cce_r);
      `REG_STATUS:  prdata_o = 32'(phase_i);
      default:      prdata_o = '0;
    endcase
  end

  assign pready_o  = 1'b1;
  assign pslverr_o = psel_i && penable_i && !mapped;
  assign lce_id_o  = lce_id_r;
  assign num_cce_o = num_cce_r;

endmodule

//--- lce_pkg.sv
// lce_pkg: vector types, command and response encodings, memory opcodes, phase enum

package lce_pkg;

  `include "lce_consts.svh"

  typedef logic [`PADDR_W-1:0] paddr_t;
  typedef logic [`INDEX_W-1:0] set_index_t;
  typedef logic [`TAG_W-1:0] tag_t;
  typedef logic [$clog2(`LCE_WAYS)-1:0] way_t;
  typedef logic [`LCE_ID_W-1:0] lce_id_t;
  typedef logic [`CCE_ID_W-1:0] cce_id_t;
  typedef logic [`BLOCK_W-1:0] block_t;

  // zero is the invalid state
  typedef logic [1:0] coh_state_t;
  localparam coh_state_t COH_I = 2'b00;

  typedef enum logic [2:0] {
    e_cmd_set_clear,
    e_cmd_sync,
    e_cmd_uc_data,
    e_cmd_set_tag,
    e_cmd_set_tag_wakeup,
    e_cmd_invalidate_tag,
    e_cmd_data,
    e_cmd_writeback
  } lce_cmd_type_e;

  typedef enum logic [1:0] {
    e_resp_sync_ack,
    e_resp_inv_ack,
    e_resp_null_wb
  } lce_resp_type_e;

  typedef enum logic [1:0] {e_tag_set_clear, e_tag_set_tag, e_tag_invalidate} tag_op_e;
  typedef enum logic [0:0] {e_stat_set_clear} stat_op_e;
  typedef enum logic [0:0] {e_data_write, e_data_uncached} data_op_e;

  // readable through the apb status register
  typedef enum logic [1:0] {
    e_phase_sweep,
    e_phase_uncached_only,
    e_phase_ready
  } lce_phase_e;

endpackage

//--- lce_consts.svh
// sizing constants for the lce command engine: cache geometry, widths, apb register offsets
`ifndef LCE_CONSTS_SVH
`define LCE_CONSTS_SVH

// cache geometry
`define LCE_SETS 8
`define LCE_WAYS 4

// physical address and block layout
`define PADDR_W 16
`define BLOCK_W 64
`define BLOCK_OFFSET_W 3
`define INDEX_W 3
`define TAG_W (`PADDR_W - `INDEX_W - `BLOCK_OFFSET_W)

// agent ids
`define LCE_ID_W 2
`define CCE_ID_W 2
`define NUM_CCE_W 3
`define MAX_CCE 4

// apb register map, byte offsets
`define APB_ADDR_W 4
`define REG_LCE_ID 4'h0
`define REG_NUM_CCE 4'h4
`define REG_STATUS 4'h8

`endif
